// File: logic/iic_reg_pkg.sv
package iic_reg_pkg;

	localparam int unsigned RegAddrW = 4; // byte address of a register
	localparam int unsigned RegDataW = 8; // register data word

	typedef logic [RegAddrW-1:0] reg_addr_t;
	typedef logic [RegDataW-1:0] reg_data_t;

	localparam reg_addr_t SdaCtrlAddr = 4'h0; // bit0 value, bit1 enable
	localparam reg_addr_t SclCtrlAddr = 4'h4; // same layout as sda
	localparam reg_addr_t StatusAddr  = 4'h8; // read only
	localparam reg_addr_t EventAddr   = 4'hc; // write one to clear

	localparam int unsigned CtrlValBit  = 0;
	localparam int unsigned CtrlEnBit   = 1;
	localparam int unsigned StatSdaBit  = 0;
	localparam int unsigned StatSclBit  = 1;
	localparam int unsigned StatBusyBit = 2;
	localparam int unsigned EvStartBit  = 0;
	localparam int unsigned EvStopBit   = 1;

	// one pin's control field as seen by the pad logic
	typedef struct packed {
		logic val; // output value
		logic en;  // output enable
		logic qe;  // one-cycle update strobe
	} pin_ctrl_t;

	typedef struct packed {
		pin_ctrl_t sda;
		pin_ctrl_t scl;
	} reg2hw_t;

endpackage

// File: logic/iic_bus_pkg.sv
package iic_bus_pkg;

	// one bit per bus line
	typedef struct packed {
		logic sda;
		logic scl;
	} line_t;

	// released bus, both lines pulled up
	localparam line_t LineIdle = '{sda: 1'b1, scl: 1'b1};

	typedef enum logic {
		MonIdle,
		MonBusy
	} mon_state_e;

	// single-cycle pulses from the monitor
	typedef struct packed {
		logic start;
		logic stop;
	} bus_event_t;

endpackage

// File: logic/iic_reg_block.sv
module iic_reg_block (
	input  logic                    clk_i,
	input  logic                    rst_ni,
	input  logic                    reg_we_i,
	input  logic                    reg_re_i,
	input  iic_reg_pkg::reg_addr_t  reg_addr_i,
	input  iic_reg_pkg::reg_data_t  reg_wdata_i,
	output iic_reg_pkg::reg_data_t  reg_rdata_o,
	output logic                    reg_err_o,
	output iic_reg_pkg::reg2hw_t    reg2hw_o,
	input  iic_bus_pkg::line_t      pin_en_i,
	input  iic_bus_pkg::line_t      line_i,
	input  iic_bus_pkg::bus_event_t event_i,
	input  logic                    busy_i
);

	logic sda_hit;
	logic scl_hit;
	logic status_hit;
	logic event_hit;
	logic rd_err;
	logic wr_err;
	logic ev_clr; // write-one-to-clear access

	iic_reg_pkg::reg2hw_t    ctrl_q;
	iic_bus_pkg::line_t      sample_q;
	iic_bus_pkg::bus_event_t sticky_q;
	iic_reg_pkg::reg_data_t  rdata_d;
	iic_reg_pkg::reg_data_t  rdata_q;
	logic                    err_q;

	assign sda_hit    = (reg_addr_i == iic_reg_pkg::SdaCtrlAddr);
	assign scl_hit    = (reg_addr_i == iic_reg_pkg::SclCtrlAddr);
	assign status_hit = (reg_addr_i == iic_reg_pkg::StatusAddr);
	assign event_hit  = (reg_addr_i == iic_reg_pkg::EventAddr);

	assign rd_err = ~(sda_hit | scl_hit | status_hit | event_hit);
	assign wr_err = ~(sda_hit | scl_hit | event_hit); // status is read only
	assign ev_clr = reg_we_i & event_hit;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			ctrl_q <= '0;
		end else begin
			ctrl_q.sda.qe <= reg_we_i & sda_hit; // pad loads one cycle later
			ctrl_q.scl.qe <= reg_we_i & scl_hit;
			if (reg_we_i && sda_hit) begin
				ctrl_q.sda.val <= reg_wdata_i[iic_reg_pkg::CtrlValBit];
				ctrl_q.sda.en  <= reg_wdata_i[iic_reg_pkg::CtrlEnBit];
			end
			if (reg_we_i && scl_hit) begin
				ctrl_q.scl.val <= reg_wdata_i[iic_reg_pkg::CtrlValBit];
				ctrl_q.scl.en  <= reg_wdata_i[iic_reg_pkg::CtrlEnBit];
			end
		end
	end

	assign reg2hw_o = ctrl_q;

	// a driven pin keeps its last released sample
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			sample_q <= '0;
		end else begin
			if (!pin_en_i.sda) sample_q.sda <= line_i.sda;
			if (!pin_en_i.scl) sample_q.scl <= line_i.scl;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			sticky_q <= '0;
		end else begin
			// a new event beats a clear in the same cycle
			sticky_q.start <= event_i.start |
				(sticky_q.start & ~(ev_clr & reg_wdata_i[iic_reg_pkg::EvStartBit]));
			sticky_q.stop  <= event_i.stop |
				(sticky_q.stop & ~(ev_clr & reg_wdata_i[iic_reg_pkg::EvStopBit]));
		end
	end

	always_comb begin
		rdata_d = '0; // also the value for unmapped reads
		if (sda_hit) begin
			rdata_d[iic_reg_pkg::CtrlValBit] = ctrl_q.sda.val;
			rdata_d[iic_reg_pkg::CtrlEnBit]  = ctrl_q.sda.en;
		end else if (scl_hit) begin
			rdata_d[iic_reg_pkg::CtrlValBit] = ctrl_q.scl.val;
			rdata_d[iic_reg_pkg::CtrlEnBit]  = ctrl_q.scl.en;
		end else if (status_hit) begin
			rdata_d[iic_reg_pkg::StatSdaBit]  = sample_q.sda;
			rdata_d[iic_reg_pkg::StatSclBit]  = sample_q.scl;
			rdata_d[iic_reg_pkg::StatBusyBit] = busy_i;
		end else if (event_hit) begin
			rdata_d[iic_reg_pkg::EvStartBit] = sticky_q.start;
			rdata_d[iic_reg_pkg::EvStopBit]  = sticky_q.stop;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			rdata_q <= '0;
			err_q   <= 1'b0;
		end else if (reg_re_i) begin
			rdata_q <= rdata_d;
			err_q   <= rd_err;
		end else if (reg_we_i) begin
			err_q <= wr_err; // read data holds
		end
	end

	assign reg_rdata_o = rdata_q;
	assign reg_err_o   = err_q;

endmodule

// File: logic/iic_pad_ctrl.sv
module iic_pad_ctrl (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  iic_reg_pkg::reg2hw_t reg2hw_i,
	output iic_bus_pkg::line_t   pin_en_o,
	output iic_bus_pkg::line_t   line_sync_o,
	inout  wire                  sda_io,
	inout  wire                  scl_io
);

	iic_bus_pkg::line_t out_q; // loaded drive values
	iic_bus_pkg::line_t en_q;  // loaded drive enables
	iic_bus_pkg::line_t raw;
	iic_bus_pkg::line_t sync1_q;
	iic_bus_pkg::line_t sync2_q;

	// each pin loads only on its own update strobe
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			out_q <= '0;
			en_q  <= '0;
		end else begin
			if (reg2hw_i.sda.qe) begin
				out_q.sda <= reg2hw_i.sda.val;
				en_q.sda  <= reg2hw_i.sda.en;
			end
			if (reg2hw_i.scl.qe) begin
				out_q.scl <= reg2hw_i.scl.val;
				en_q.scl  <= reg2hw_i.scl.en;
			end
		end
	end

	// pad drivers, released lines go to the pull-ups
	assign sda_io = en_q.sda ? out_q.sda : 1'bz;
	assign scl_io = en_q.scl ? out_q.scl : 1'bz;

	assign raw.sda = sda_io;
	assign raw.scl = scl_io;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			sync1_q <= iic_bus_pkg::LineIdle;
			sync2_q <= iic_bus_pkg::LineIdle;
		end else begin
			sync1_q <= raw;     // may go metastable
			sync2_q <= sync1_q;
		end
	end

	assign pin_en_o    = en_q;
	assign line_sync_o = sync2_q;

endmodule

// File: logic/iic_line_filter.sv
module iic_line_filter #(
	parameter int unsigned FiltCycles = 4
) (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  iic_bus_pkg::line_t line_i,
	output iic_bus_pkg::line_t line_o
);

	localparam int unsigned NumLines = $bits(iic_bus_pkg::line_t);
	localparam int unsigned CntW     = (FiltCycles > 2) ? $clog2(FiltCycles) : 1;
	localparam logic [CntW-1:0] CntMax = CntW'(FiltCycles - 1); // counts from zero

	logic [NumLines-1:0] in_bits;
	logic [NumLines-1:0] out_bits;

	assign in_bits = line_i;

	for (genvar i = 0; i < NumLines; i++) begin : g_line
		logic            prev_q;
		logic [CntW-1:0] cnt_q;
		logic            out_q;

		always_ff @(posedge clk_i or negedge rst_ni) begin
			if (!rst_ni) begin
				prev_q <= 1'b1; // idle bus level
				cnt_q  <= '0;
				out_q  <= 1'b1;
			end else begin
				prev_q <= in_bits[i];
				if (in_bits[i] != prev_q) begin
					cnt_q <= '0; // level moved, start over
				end else if (cnt_q != CntMax) begin
					cnt_q <= cnt_q + 1'b1;
				end
				if (cnt_q == CntMax) out_q <= prev_q;
			end
		end

		assign out_bits[i] = out_q;
	end

	assign line_o = out_bits;

endmodule

// File: logic/iic_bus_monitor.sv
module iic_bus_monitor (
	input  logic                    clk_i,
	input  logic                    rst_ni,
	input  iic_bus_pkg::line_t      line_i,
	output iic_bus_pkg::bus_event_t event_o,
	output logic                    busy_o
);

	iic_bus_pkg::line_t      prev_q;
	iic_bus_pkg::bus_event_t det;
	iic_bus_pkg::bus_event_t event_q;
	iic_bus_pkg::mon_state_e state_q;
	iic_bus_pkg::mon_state_e state_d;

	// sda edge with scl high both before and after
	assign det.start = prev_q.sda & ~line_i.sda & prev_q.scl & line_i.scl;
	assign det.stop  = ~prev_q.sda & line_i.sda & prev_q.scl & line_i.scl;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			prev_q  <= iic_bus_pkg::LineIdle;
			event_q <= '0;
		end else begin
			prev_q  <= line_i;
			event_q <= det;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			iic_bus_pkg::MonIdle: begin
				if (event_q.start) state_d = iic_bus_pkg::MonBusy;
			end
			iic_bus_pkg::MonBusy: begin
				if (event_q.stop) state_d = iic_bus_pkg::MonIdle; // repeated start stays busy
			end
			default: state_d = iic_bus_pkg::MonIdle;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= iic_bus_pkg::MonIdle;
		end else begin
			state_q <= state_d;
		end
	end

	assign event_o = event_q;
	assign busy_o  = (state_q == iic_bus_pkg::MonBusy);

endmodule

// File: logic/iic_pins_top.sv
module iic_pins_top #(
	parameter int unsigned FiltCycles = 4
) (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	input  logic                   reg_we_i,
	input  logic                   reg_re_i,
	input  iic_reg_pkg::reg_addr_t reg_addr_i,
	input  iic_reg_pkg::reg_data_t reg_wdata_i,
	output iic_reg_pkg::reg_data_t reg_rdata_o,
	output logic                   reg_err_o,
	inout  wire                    sda_io,
	inout  wire                    scl_io
);

	iic_reg_pkg::reg2hw_t    reg2hw;
	iic_bus_pkg::line_t      pin_en;
	iic_bus_pkg::line_t      line_sync;
	iic_bus_pkg::line_t      line_filt;
	iic_bus_pkg::bus_event_t bus_event;
	logic                    busy;

	iic_reg_block i_iic_reg_block (
		.clk_i,
		.rst_ni,
		.reg_we_i,
		.reg_re_i,
		.reg_addr_i,
		.reg_wdata_i,
		.reg_rdata_o,
		.reg_err_o,
		.reg2hw_o (reg2hw),
		.pin_en_i (pin_en),
		.line_i   (line_filt),
		.event_i  (bus_event),
		.busy_i   (busy)
	);

	iic_pad_ctrl i_iic_pad_ctrl (
		.clk_i,
		.rst_ni,
		.reg2hw_i    (reg2hw),
		.pin_en_o    (pin_en),
		.line_sync_o (line_sync),
		.sda_io,
		.scl_io
	);

	iic_line_filter #(
		.FiltCycles (FiltCycles)
	) i_iic_line_filter (
		.clk_i,
		.rst_ni,
		.line_i (line_sync),
		.line_o (line_filt)
	);

	iic_bus_monitor i_iic_bus_monitor (
		.clk_i,
		.rst_ni,
		.line_i  (line_filt),
		.event_o (bus_event),
		.busy_o  (busy)
	);

endmodule

// File: tests/iic_pins_checker.sv
module iic_pins_checker (
	input logic                   clk_i,
	input logic                   rst_ni,
	input logic                   reg_we_i,
	input logic                   reg_re_i,
	input iic_reg_pkg::reg_addr_t reg_addr_i,
	input iic_reg_pkg::reg_data_t reg_wdata_i,
	input logic                   reg_err_o,
	input wire                    sda_io,
	input wire                    scl_io
);

	logic sda_off; // sda enable written low
	logic scl_off;
	int unsigned fail_cnt = 0; // failed assertions so far

	assign sda_off = reg_we_i && (reg_addr_i == iic_reg_pkg::SdaCtrlAddr) &&
		!reg_wdata_i[iic_reg_pkg::CtrlEnBit];
	assign scl_off = reg_we_i && (reg_addr_i == iic_reg_pkg::SclCtrlAddr) &&
		!reg_wdata_i[iic_reg_pkg::CtrlEnBit];

	strobe_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!(reg_we_i && reg_re_i))
		else begin
			fail_cnt++;
			$error("write and read strobes high in the same cycle");
		end

	err_after_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
		$rose(reg_err_o) |-> $past(reg_we_i || reg_re_i))
		else begin
			fail_cnt++;
			$error("reg_err_o rose without a strobe in the cycle before");
		end

	// pad releases one cycle after the register update
	sda_released: assert property (@(posedge clk_i) disable iff (!rst_ni)
		sda_off |-> ##2 (sda_io !== 1'b0))
		else begin
			fail_cnt++;
			$error("sda still driven low after its enable was cleared");
		end

	scl_released: assert property (@(posedge clk_i) disable iff (!rst_ni)
		scl_off |-> ##2 (scl_io !== 1'b0))
		else begin
			fail_cnt++;
			$error("scl still driven low after its enable was cleared");
		end

endmodule

// File: tests/iic_pins_tb.sv
module iic_pins_tb;

	localparam int unsigned FiltCycles = 4;
	localparam int unsigned PollLimit  = 50; // status reads before giving up
	localparam int unsigned Settle     = 2 * FiltCycles + 6; // sync, filter and event delay

	logic                   clk_i;
	logic                   rst_ni;
	logic                   reg_we_i;
	logic                   reg_re_i;
	iic_reg_pkg::reg_addr_t reg_addr_i;
	iic_reg_pkg::reg_data_t reg_wdata_i;
	iic_reg_pkg::reg_data_t reg_rdata_o;
	logic                   reg_err_o;
	logic                   ext_sda_low; // other devices on the bus
	logic                   ext_scl_low;
	tri1                    sda_io;
	tri1                    scl_io;
	int unsigned            num_checks;
	int unsigned            num_errors;

	assign sda_io = ext_sda_low ? 1'b0 : 1'bz;
	assign scl_io = ext_scl_low ? 1'b0 : 1'bz;

	iic_pins_top #(.FiltCycles (FiltCycles)) i_iic_pins_top (.*);

	bind iic_pins_top iic_pins_checker i_iic_pins_checker (.*);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
		num_checks++;
		if (got !== exp) begin
			num_errors++;
			$display("Fail %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic reg_write(input iic_reg_pkg::reg_addr_t addr,
		input iic_reg_pkg::reg_data_t data, input logic exp_err);
		@(posedge clk_i);
		reg_we_i    <= 1'b1;
		reg_addr_i  <= addr;
		reg_wdata_i <= data;
		@(posedge clk_i);
		reg_we_i <= 1'b0;
		@(negedge clk_i); // error flag settled
		check_val("reg_err_o", reg_err_o, exp_err);
	endtask

	task automatic reg_read(input iic_reg_pkg::reg_addr_t addr,
		output iic_reg_pkg::reg_data_t data, input logic exp_err);
		@(posedge clk_i);
		reg_re_i   <= 1'b1;
		reg_addr_i <= addr;
		@(posedge clk_i);
		reg_re_i <= 1'b0;
		@(negedge clk_i);
		check_val("reg_err_o", reg_err_o, exp_err);
		data = reg_rdata_o;
	endtask

	task automatic read_check(input iic_reg_pkg::reg_addr_t addr, input iic_reg_pkg::reg_data_t exp);
		iic_reg_pkg::reg_data_t data;
		reg_read(addr, data, 1'b0);
		check_val($sformatf("reg_rdata_o at 0x%h", addr), data, exp);
	endtask

	task automatic poll_status(input iic_reg_pkg::reg_data_t exp);
		iic_reg_pkg::reg_data_t data;
		int unsigned reads;
		reads = 0;
		do begin
			reg_read(iic_reg_pkg::StatusAddr, data, 1'b0);
			reads++;
		end while (data !== exp && reads < PollLimit);
		num_checks++;
		if (data !== exp) begin
			num_errors++;
			$display("status did not reach 0x%h within %0d reads, last read 0x%h",
				exp, PollLimit, data);
		end
	endtask

	// one cycle on, checked in the middle of the next one
	task automatic check_pins(input logic exp_sda, input logic exp_scl);
		@(negedge clk_i);
		check_val("sda_io", sda_io, exp_sda);
		check_val("scl_io", scl_io, exp_scl);
	endtask

	task automatic set_ext(input logic sda_low, input logic scl_low);
		@(posedge clk_i);
		ext_sda_low <= sda_low;
		ext_scl_low <= scl_low;
	endtask

	task automatic test_reset();
		check_pins(1'b1, 1'b1);
		check_val("reg_err_o", reg_err_o, 8'h00);
		check_val("reg_rdata_o", reg_rdata_o, 8'h00);
		read_check(iic_reg_pkg::SdaCtrlAddr, 8'h00);
		read_check(iic_reg_pkg::SclCtrlAddr, 8'h00);
		read_check(iic_reg_pkg::StatusAddr, 8'h03); // released lines sample high
		read_check(iic_reg_pkg::EventAddr, 8'h00);
	endtask

	task automatic test_drive();
		iic_reg_pkg::reg_data_t data;
		for (int i = 0; i < 8; i++) begin
			data = (8'($urandom) & 8'hfc) | 8'h02 | 8'((i / 2) % 2); // low and high per pin
			reg_write((i % 2) ? iic_reg_pkg::SclCtrlAddr : iic_reg_pkg::SdaCtrlAddr, data, 1'b0);
			if (i % 2) check_pins(1'b1, data[0]);
			else check_pins(data[0], 1'b1);
			read_check((i % 2) ? iic_reg_pkg::SclCtrlAddr : iic_reg_pkg::SdaCtrlAddr, data & 8'h03);
			reg_write((i % 2) ? iic_reg_pkg::SclCtrlAddr : iic_reg_pkg::SdaCtrlAddr, 8'h00, 1'b0);
			check_pins(1'b1, 1'b1);
			repeat (Settle) @(posedge clk_i);
		end
		poll_status(8'h03);
		read_check(iic_reg_pkg::EventAddr, 8'h03); // low sda pulses give start and stop
		reg_write(iic_reg_pkg::EventAddr, 8'h03, 1'b0);
		read_check(iic_reg_pkg::EventAddr, 8'h00);
	endtask

	task automatic test_ext_lines();
		set_ext(1'b0, 1'b1);
		poll_status(8'h01);
		set_ext(1'b1, 1'b1);
		poll_status(8'h00);
		set_ext(1'b0, 1'b1); // sda rises with scl low, no stop
		poll_status(8'h01);
		set_ext(1'b0, 1'b0);
		poll_status(8'h03);
		read_check(iic_reg_pkg::EventAddr, 8'h00);
	endtask

	task automatic test_hold();
		reg_write(iic_reg_pkg::SclCtrlAddr, 8'h02, 1'b0); // scl low first, no start
		check_pins(1'b1, 1'b0);
		reg_write(iic_reg_pkg::SdaCtrlAddr, 8'h02, 1'b0);
		check_pins(1'b0, 1'b0);
		for (int i = 0; i < 3 * FiltCycles; i++) read_check(iic_reg_pkg::StatusAddr, 8'h03);
		reg_write(iic_reg_pkg::SdaCtrlAddr, 8'h00, 1'b0);
		reg_write(iic_reg_pkg::SclCtrlAddr, 8'h00, 1'b0);
		check_pins(1'b1, 1'b1);
		poll_status(8'h03);
		read_check(iic_reg_pkg::EventAddr, 8'h00);
	endtask

	task automatic test_events();
		set_ext(1'b1, 1'b0); // start
		poll_status(8'h06);
		read_check(iic_reg_pkg::EventAddr, 8'h01);
		set_ext(1'b0, 1'b0); // stop
		poll_status(8'h03);
		read_check(iic_reg_pkg::EventAddr, 8'h03);
		reg_write(iic_reg_pkg::EventAddr, 8'h01, 1'b0);
		read_check(iic_reg_pkg::EventAddr, 8'h02);
		reg_write(iic_reg_pkg::EventAddr, 8'h02, 1'b0);
		read_check(iic_reg_pkg::EventAddr, 8'h00);
		@(posedge clk_i);
		ext_sda_low <= 1'b1; // glitch shorter than the filter
		repeat (FiltCycles - 1) @(posedge clk_i);
		ext_sda_low <= 1'b0;
		repeat (Settle) @(posedge clk_i);
		read_check(iic_reg_pkg::EventAddr, 8'h00);
		read_check(iic_reg_pkg::StatusAddr, 8'h03);
	endtask

	task automatic test_errors();
		iic_reg_pkg::reg_data_t data;
		set_ext(1'b1, 1'b0); // start and stop leave both event bits set
		poll_status(8'h06);
		set_ext(1'b0, 1'b0);
		poll_status(8'h03);
		reg_write(iic_reg_pkg::SdaCtrlAddr, 8'h01, 1'b0); // value only, pin stays released
		reg_read(4'h1, data, 1'b1);
		reg_read(4'hf, data, 1'b1);
		reg_write(4'h2, 8'hff, 1'b1);
		reg_write(4'hd, 8'hff, 1'b1);
		reg_write(iic_reg_pkg::StatusAddr, 8'hff, 1'b1);
		check_pins(1'b1, 1'b1);
		read_check(iic_reg_pkg::SdaCtrlAddr, 8'h01);
		read_check(iic_reg_pkg::SclCtrlAddr, 8'h00);
		read_check(iic_reg_pkg::StatusAddr, 8'h03);
		read_check(iic_reg_pkg::EventAddr, 8'h03);
	endtask

	initial begin
		void'($urandom(32'hb753_9665));
		num_checks  = 0;
		num_errors  = 0;
		rst_ni      = 1'b0;
		reg_we_i    = 1'b0;
		reg_re_i    = 1'b0;
		reg_addr_i  = '0;
		reg_wdata_i = '0;
		ext_sda_low = 1'b0;
		ext_scl_low = 1'b0;
		repeat (2) @(posedge clk_i);
		rst_ni <= 1'b1;
		test_reset();
		test_drive();
		test_ext_lines();
		test_hold();
		test_events();
		test_errors();
		$display("checks: %0d, errors: %0d, assertion failures: %0d", num_checks, num_errors,
			i_iic_pins_top.i_iic_pins_checker.fail_cnt);
		if (num_errors == 0 && i_iic_pins_top.i_iic_pins_checker.fail_cnt == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: iic_pins.f
logic/iic_reg_pkg.sv
logic/iic_bus_pkg.sv
logic/iic_reg_block.sv
logic/iic_pad_ctrl.sv
logic/iic_line_filter.sv
logic/iic_bus_monitor.sv
logic/iic_pins_top.sv
tests/iic_pins_checker.sv
tests/iic_pins_tb.sv
